//--- hdl/adv_timer_pkg.sv
// Two-timer PWM block shared definitions
// Widths, APB register map, channel compare operations and the
// decoded views of an APB write word
`default_nettype none

package adv_timer_pkg;

	localparam int APB_ADDR_W = 8;
	localparam int DATA_W     = 32;
	localparam int CNT_W      = 16;
	localparam int PRESC_W    = 8;
	localparam int N_TIMERS   = 2;
	localparam int N_CH       = 2;
	localparam int N_EVENTS   = 4;
	localparam int SEL_W      = 2;

	// Each timer owns one window of the register map
	localparam int TIMER_STRIDE = 'h20;
	localparam int OFFS_W       = $clog2(TIMER_STRIDE);

	localparam logic [OFFS_W-1:0] REG_CMD     = 5'h00;
	localparam logic [OFFS_W-1:0] REG_PRESC   = 5'h04;
	localparam logic [OFFS_W-1:0] REG_RANGE   = 5'h08;
	localparam logic [OFFS_W-1:0] REG_CH0     = 5'h0C;
	localparam logic [OFFS_W-1:0] REG_CH1     = 5'h10;
	localparam logic [OFFS_W-1:0] REG_COUNTER = 5'h14;

	localparam logic [APB_ADDR_W-1:0] REG_EVENT = 8'h40;
	localparam int                    EV_EN_LSB = 8;

	typedef enum logic [1:0] {
		OP_SET    = 2'd0,
		OP_TOGGLE = 2'd1,
		OP_RESET  = 2'd2,
		OP_PWM    = 2'd3
	} comp_op_t;

	// The register offset picks which view applies
	typedef union packed {
		struct packed {
			logic [DATA_W-4:0] rsvd;
			logic              rst;
			logic              stop;
			logic              start;
		} cmd;
		struct packed {
			logic [CNT_W-1:0] th_high;
			logic [CNT_W-1:0] th_low;
		} range;
		struct packed {
			logic [DATA_W-CNT_W-3:0] rsvd;
			comp_op_t                op;
			logic [CNT_W-1:0]        cmp;
		} ch;
	} reg_wdata_u;

endpackage

`default_nettype wire

//--- hdl/adv_timer_regs.sv
// APB register slave for the two-timer PWM block
// Decodes the timer window and offset, keeps the timer and event
// configuration and turns command writes into one-cycle pulses
`timescale 1ns/1ps
`default_nettype none

module adv_timer_regs (
	input  logic                                          HCLK,
	input  logic                                          HRESETn,
	input  logic [adv_timer_pkg::APB_ADDR_W-1:0]          paddr_i,
	input  logic [adv_timer_pkg::DATA_W-1:0]              pwdata_i,
	input  logic                                          pwrite_i,
	input  logic                                          psel_i,
	input  logic                                          penable_i,
	output logic [adv_timer_pkg::DATA_W-1:0]              prdata_o,
	output logic                                          pready_o,
	output logic                                          pslverr_o,
	output logic [adv_timer_pkg::N_TIMERS-1:0]            start_o,
	output logic [adv_timer_pkg::N_TIMERS-1:0]            stop_o,
	output logic [adv_timer_pkg::N_TIMERS-1:0]            rst_o,
	output logic [adv_timer_pkg::N_TIMERS-1:0][adv_timer_pkg::PRESC_W-1:0] presc_o,
	output logic [adv_timer_pkg::N_TIMERS-1:0][adv_timer_pkg::CNT_W-1:0]   th_low_o,
	output logic [adv_timer_pkg::N_TIMERS-1:0][adv_timer_pkg::CNT_W-1:0]   th_high_o,
	output logic [adv_timer_pkg::N_TIMERS-1:0][adv_timer_pkg::N_CH-1:0]
	             [adv_timer_pkg::CNT_W-1:0]               cmp_o,
	output adv_timer_pkg::comp_op_t [adv_timer_pkg::N_TIMERS-1:0]
	                                [adv_timer_pkg::N_CH-1:0] op_o,
	output logic [adv_timer_pkg::N_EVENTS-1:0]            ev_en_o,
	output logic [adv_timer_pkg::N_EVENTS-1:0][adv_timer_pkg::SEL_W-1:0] ev_sel_o,
	input  logic [adv_timer_pkg::N_TIMERS-1:0][adv_timer_pkg::CNT_W-1:0] counter_i
);

	import adv_timer_pkg::*;

	logic                         acc;
	logic                         wr_en;
	logic                         mapped;
	logic [APB_ADDR_W-OFFS_W-1:0] tidx;
	logic [OFFS_W-1:0]            offs;
	logic [DATA_W-1:0]            rdata;
	reg_wdata_u                   wdata;

	assign acc   = psel_i & penable_i;
	assign wr_en = acc & pwrite_i;
	assign tidx  = paddr_i[APB_ADDR_W-1:OFFS_W];
	assign offs  = paddr_i[OFFS_W-1:0];
	assign wdata = pwdata_i;

	// Zero wait states, every access ends in its access phase
	assign pready_o  = 1'b1;
	assign pslverr_o = acc & ~mapped;
	assign prdata_o  = rdata;

	////////////////////////////////////////////////////////////
	// Read decode
	////////////////////////////////////////////////////////////
	always_comb begin
		rdata  = '0;
		mapped = 1'b0;
		for (int t = 0; t < N_TIMERS; t++) begin
			if (tidx == t) begin
				mapped = 1'b1;
				case (offs)
					// Commands read back as zero
					REG_CMD: ;
					REG_PRESC:   rdata[PRESC_W-1:0] = presc_o[t];
					REG_RANGE:   rdata = {th_high_o[t], th_low_o[t]};
					REG_CH0: begin
						rdata[CNT_W-1:0]                = cmp_o[t][0];
						rdata[CNT_W +: $bits(comp_op_t)] = op_o[t][0];
					end
					REG_CH1: begin
						rdata[CNT_W-1:0]                = cmp_o[t][1];
						rdata[CNT_W +: $bits(comp_op_t)] = op_o[t][1];
					end
					REG_COUNTER: rdata[CNT_W-1:0] = counter_i[t];
					default:     mapped = 1'b0;
				endcase
			end
		end
		if (paddr_i == REG_EVENT) begin
			mapped                        = 1'b1;
			rdata[N_EVENTS*SEL_W-1:0]     = ev_sel_o;
			rdata[EV_EN_LSB +: N_EVENTS]  = ev_en_o;
		end
	end

	////////////////////////////////////////////////////////////
	// Configuration storage and command pulses
	////////////////////////////////////////////////////////////
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			start_o   <= '0;
			stop_o    <= '0;
			rst_o     <= '0;
			presc_o   <= '0;
			th_low_o  <= '0;
			th_high_o <= '0;
			cmp_o     <= '0;
			ev_en_o   <= '0;
			ev_sel_o  <= '0;
			for (int t = 0; t < N_TIMERS; t++) begin
				for (int c = 0; c < N_CH; c++) begin
					op_o[t][c] <= OP_SET;
				end
			end
		end else begin
			start_o <= '0;
			stop_o  <= '0;
			rst_o   <= '0;
			if (wr_en) begin
				for (int t = 0; t < N_TIMERS; t++) begin
					if (tidx == t) begin
						case (offs)
							REG_CMD: begin
								start_o[t] <= wdata.cmd.start;
								stop_o[t]  <= wdata.cmd.stop;
								rst_o[t]   <= wdata.cmd.rst;
							end
							REG_PRESC: presc_o[t] <= pwdata_i[PRESC_W-1:0];
							REG_RANGE: begin
								th_low_o[t]  <= wdata.range.th_low;
								th_high_o[t] <= wdata.range.th_high;
							end
							REG_CH0: begin
								cmp_o[t][0] <= wdata.ch.cmp;
								op_o[t][0]  <= wdata.ch.op;
							end
							REG_CH1: begin
								cmp_o[t][1] <= wdata.ch.cmp;
								op_o[t][1]  <= wdata.ch.op;
							end
							default: ;
						endcase
					end
				end
				if (paddr_i == REG_EVENT) begin
					ev_sel_o <= pwdata_i[N_EVENTS*SEL_W-1:0];
					ev_en_o  <= pwdata_i[EV_EN_LSB +: N_EVENTS];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/timer_unit.sv
// Single PWM timer
// Prescaler, sawtooth counter between two thresholds and two
// compare channels with registered outputs
`timescale 1ns/1ps
`default_nettype none

module timer_unit (
	input  logic                                          HCLK,
	input  logic                                          HRESETn,
	input  logic                                          start_i,
	input  logic                                          stop_i,
	input  logic                                          rst_i,
	input  logic [adv_timer_pkg::PRESC_W-1:0]             presc_i,
	input  logic [adv_timer_pkg::CNT_W-1:0]               th_low_i,
	input  logic [adv_timer_pkg::CNT_W-1:0]               th_high_i,
	input  logic [adv_timer_pkg::N_CH-1:0][adv_timer_pkg::CNT_W-1:0] cmp_i,
	input  adv_timer_pkg::comp_op_t [adv_timer_pkg::N_CH-1:0]       op_i,
	output logic [adv_timer_pkg::CNT_W-1:0]               counter_o,
	output logic [adv_timer_pkg::N_CH-1:0]                ch_o
);

	import adv_timer_pkg::*;

	logic               running;
	logic [PRESC_W-1:0] psc_cnt;
	logic               tick;
	logic               wrap;
	logic [CNT_W-1:0]   cnt_q;
	logic [N_CH-1:0]    match;
	logic [N_CH-1:0]    ch_d;
	logic [N_CH-1:0]    ch_q;

	assign tick      = running & (psc_cnt == presc_i);
	assign wrap      = (cnt_q == th_high_i);
	assign counter_o = cnt_q;
	assign ch_o      = ch_q;

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			running <= 1'b0;
		end else if (start_i) begin
			running <= 1'b1;
		end else if (stop_i) begin
			running <= 1'b0;
		end
	end

	// A start begins a fresh prescale interval on the next cycle
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			psc_cnt <= '0;
		end else if (start_i || rst_i || tick) begin
			psc_cnt <= '0;
		end else if (running) begin
			psc_cnt <= psc_cnt + 1'b1;
		end
	end

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			cnt_q <= '0;
		end else if (rst_i) begin
			cnt_q <= th_low_i;
		end else if (tick) begin
			cnt_q <= wrap ? th_low_i : cnt_q + 1'b1;
		end
	end

	// Matches compare against the counter value before the tick
	always_comb begin
		for (int c = 0; c < N_CH; c++) begin
			match[c] = (cmp_i[c] == cnt_q);
			ch_d[c]  = ch_q[c];
			case (op_i[c])
				OP_SET:    if (match[c]) ch_d[c] = 1'b1;
				OP_TOGGLE: if (match[c]) ch_d[c] = ~ch_q[c];
				OP_RESET:  if (match[c]) ch_d[c] = 1'b0;
				OP_PWM: begin
					// Wrap clear has priority over a same-tick match
					if (wrap) begin
						ch_d[c] = 1'b0;
					end else if (match[c]) begin
						ch_d[c] = 1'b1;
					end
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			ch_q <= '0;
		end else if (rst_i) begin
			ch_q <= '0;
		end else if (tick) begin
			ch_q <= ch_d;
		end
	end

endmodule

`default_nettype wire

//--- hdl/event_gen.sv
// Event generator
// Each event picks one timer channel, keeps a two-stage history of it
// and pulses for one cycle on a rising edge
`timescale 1ns/1ps
`default_nettype none

module event_gen (
	input  logic                                             HCLK,
	input  logic                                             HRESETn,
	input  logic [adv_timer_pkg::N_TIMERS*adv_timer_pkg::N_CH-1:0] ch_i,
	input  logic [adv_timer_pkg::N_EVENTS-1:0]               en_i,
	input  logic [adv_timer_pkg::N_EVENTS-1:0][adv_timer_pkg::SEL_W-1:0] sel_i,
	output logic [adv_timer_pkg::N_EVENTS-1:0]               events_o
);

	import adv_timer_pkg::*;

	// Bit 1 holds the newer sample and bit 0 the older one
	logic [N_EVENTS-1:0][1:0] hist;

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			hist     <= '0;
			events_o <= '0;
		end else begin
			for (int k = 0; k < N_EVENTS; k++) begin
				if (en_i[k]) begin
					hist[k] <= {ch_i[sel_i[k]], hist[k][1]};
				end
				events_o[k] <= en_i[k] & hist[k][1] & ~hist[k][0];
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/adv_timer_top.sv
// Two-timer PWM block with APB register port
// Joins the register slave, both timers and the event generator
`timescale 1ns/1ps
`default_nettype none

module adv_timer_top (
	input  logic                                          HCLK,
	input  logic                                          HRESETn,
	input  logic [adv_timer_pkg::APB_ADDR_W-1:0]          paddr_i,
	input  logic [adv_timer_pkg::DATA_W-1:0]              pwdata_i,
	input  logic                                          pwrite_i,
	input  logic                                          psel_i,
	input  logic                                          penable_i,
	output logic [adv_timer_pkg::DATA_W-1:0]              prdata_o,
	output logic                                          pready_o,
	output logic                                          pslverr_o,
	output logic [adv_timer_pkg::N_TIMERS*adv_timer_pkg::N_CH-1:0] ch_o,
	output logic [adv_timer_pkg::N_EVENTS-1:0]            events_o
);

	import adv_timer_pkg::*;

	logic [N_TIMERS-1:0]                       start;
	logic [N_TIMERS-1:0]                       stop;
	logic [N_TIMERS-1:0]                       rst;
	logic [N_TIMERS-1:0][PRESC_W-1:0]          presc;
	logic [N_TIMERS-1:0][CNT_W-1:0]            th_low;
	logic [N_TIMERS-1:0][CNT_W-1:0]            th_high;
	logic [N_TIMERS-1:0][CNT_W-1:0]            counter;
	logic [N_TIMERS-1:0][N_CH-1:0][CNT_W-1:0]  cmp;
	comp_op_t [N_TIMERS-1:0][N_CH-1:0]         op;
	logic [N_EVENTS-1:0]                       ev_en;
	logic [N_EVENTS-1:0][SEL_W-1:0]            ev_sel;

	adv_timer_regs u_regs (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.paddr_i   (paddr_i),
		.pwdata_i  (pwdata_i),
		.pwrite_i  (pwrite_i),
		.psel_i    (psel_i),
		.penable_i (penable_i),
		.prdata_o  (prdata_o),
		.pready_o  (pready_o),
		.pslverr_o (pslverr_o),
		.start_o   (start),
		.stop_o    (stop),
		.rst_o     (rst),
		.presc_o   (presc),
		.th_low_o  (th_low),
		.th_high_o (th_high),
		.cmp_o     (cmp),
		.op_o      (op),
		.ev_en_o   (ev_en),
		.ev_sel_o  (ev_sel),
		.counter_i (counter)
	);

	////////////////////////////////////////////////////////////
	// Timers, channel outputs packed as timer * N_CH + channel
	////////////////////////////////////////////////////////////
	timer_unit u_timer0 (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.start_i   (start[0]),
		.stop_i    (stop[0]),
		.rst_i     (rst[0]),
		.presc_i   (presc[0]),
		.th_low_i  (th_low[0]),
		.th_high_i (th_high[0]),
		.cmp_i     (cmp[0]),
		.op_i      (op[0]),
		.counter_o (counter[0]),
		.ch_o      (ch_o[0 +: N_CH])
	);

	timer_unit u_timer1 (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.start_i   (start[1]),
		.stop_i    (stop[1]),
		.rst_i     (rst[1]),
		.presc_i   (presc[1]),
		.th_low_i  (th_low[1]),
		.th_high_i (th_high[1]),
		.cmp_i     (cmp[1]),
		.op_i      (op[1]),
		.counter_o (counter[1]),
		.ch_o      (ch_o[N_CH +: N_CH])
	);

	event_gen u_events (
		.HCLK     (HCLK),
		.HRESETn  (HRESETn),
		.ch_i     (ch_o),
		.en_i     (ev_en),
		.sel_i    (ev_sel),
		.events_o (events_o)
	);

endmodule

`default_nettype wire

//--- include/tb_apb_tasks.svh
// APB master tasks and error bookkeeping for the timer testbench
// Included in the testbench module body, which provides HCLK and the
// APB signals paddr, pwdata, pwrite, psel, penable, prdata, pready, pslverr
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

int err_cnt = 0;

function automatic void note_err(input string test, input logic [31:0] exp,
		input logic [31:0] act);
	err_cnt++;
	$display("ERR %s expected %0h actual %0h", test, exp, act);
endfunction

function automatic void check_eq(input string test, input logic [31:0] exp,
		input logic [31:0] act);
	assert (exp === act) else note_err(test, exp, act);
endfunction

// Setup phase on one falling edge, access phase on the next
task automatic apb_write(input logic [adv_timer_pkg::APB_ADDR_W-1:0] addr,
		input logic [adv_timer_pkg::DATA_W-1:0] data, output logic err);
	@(negedge HCLK);
	paddr   = addr;
	pwdata  = data;
	pwrite  = 1'b1;
	psel    = 1'b1;
	penable = 1'b0;
	@(negedge HCLK);
	penable = 1'b1;
	#1;
	check_eq("apb_write pready", 32'd1, {31'd0, pready});
	err = pslverr;
	@(negedge HCLK);
	psel    = 1'b0;
	penable = 1'b0;
	pwrite  = 1'b0;
endtask

task automatic apb_read(input logic [adv_timer_pkg::APB_ADDR_W-1:0] addr,
		output logic [adv_timer_pkg::DATA_W-1:0] data, output logic err);
	@(negedge HCLK);
	paddr   = addr;
	pwrite  = 1'b0;
	psel    = 1'b1;
	penable = 1'b0;
	@(negedge HCLK);
	penable = 1'b1;
	#1;
	check_eq("apb_read pready", 32'd1, {31'd0, pready});
	data = prdata;
	err  = pslverr;
	@(negedge HCLK);
	psel    = 1'b0;
	penable = 1'b0;
endtask

`endif

//--- tests/tb_adv_timer.sv
// Testbench for the two-timer PWM block
// Drives the APB port on falling edges and checks register access,
// counter control, PWM timing, match operations and event pulses
`timescale 1ns/1ps
`default_nettype none

module tb_adv_timer;

	import adv_timer_pkg::*;

	// Longest timer period in ticks used by any test
	localparam int MAX_TICKS = 64;
	localparam int TIMEOUT = MAX_TICKS * (4 * 1 + 4 * 4 + 5 * 2 + 6 * 2 + 6 * 2) + 2000;
	localparam logic [APB_ADDR_W-1:0] BAD_ADDR  = 8'h60;
	localparam logic [DATA_W-1:0]     CMD_START = 32'h1;
	localparam logic [DATA_W-1:0]     CMD_STOP  = 32'h2;
	localparam logic [DATA_W-1:0]     CMD_RST   = 32'h4;

	logic                       HCLK = 1'b0;
	logic                       HRESETn;
	logic [APB_ADDR_W-1:0]      paddr;
	logic [DATA_W-1:0]          pwdata;
	logic                       pwrite;
	logic                       psel;
	logic                       penable;
	logic [DATA_W-1:0]          prdata;
	logic                       pready;
	logic                       pslverr;
	logic [N_TIMERS*N_CH-1:0]   ch;
	logic [N_EVENTS-1:0]        events;

	int                         chk_cnt = 0;
	int                         cycles = 0;
	logic                       ev_chk = 1'b0;
	logic [N_EVENTS-1:0]        ev_en_m = '0;
	logic [N_EVENTS-1:0][SEL_W-1:0] ev_sel_m = '0;
	// Channel samples from one, two and three falling edges back
	logic [N_TIMERS*N_CH-1:0]   ch_h1 = '0;
	logic [N_TIMERS*N_CH-1:0]   ch_h2 = '0;
	logic [N_TIMERS*N_CH-1:0]   ch_h3 = '0;
	int                         rise_cnt [N_EVENTS] = '{default: 0};
	int                         ev_cnt [N_EVENTS] = '{default: 0};

	`include "tb_apb_tasks.svh"

	adv_timer_top u_adv_timer_top (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.paddr_i   (paddr),
		.pwdata_i  (pwdata),
		.pwrite_i  (pwrite),
		.psel_i    (psel),
		.penable_i (penable),
		.prdata_o  (prdata),
		.pready_o  (pready),
		.pslverr_o (pslverr),
		.ch_o      (ch),
		.events_o  (events)
	);

	always #20 HCLK = ~HCLK;

	always @(posedge HCLK) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
			$display("Summary: %0d checks, %0d errors", chk_cnt, err_cnt + 1);
			$display("Done: errors found");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Protocol and event checks
	////////////////////////////////////////////////////////////
	assert property (@(posedge HCLK) disable iff (!HRESETn) (psel && penable) |-> pready)
		else note_err("apb pready", 32'd1, {31'd0, pready});

	// Only the unmapped offset may flag an error
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		(psel && penable) |-> (pslverr == (paddr == BAD_ADDR)))
		else note_err("apb pslverr", {31'd0, paddr == BAD_ADDR}, {31'd0, pslverr});

	// An event fires two cycles after its channel rises, for one cycle only
	always @(negedge HCLK) begin
		logic [N_EVENTS-1:0] exp_ev;
		int                  s;
		for (int k = 0; k < N_EVENTS; k++) begin
			s = int'(ev_sel_m[k]);
			exp_ev[k] = ev_en_m[k] & ch_h2[s] & ~ch_h3[s];
			rise_cnt[k] += int'(ev_chk && ch[s] && !ch_h1[s]);
			ev_cnt[k] += int'(ev_chk && events[k]);
		end
		if (ev_chk) begin
			chk_cnt++;
			assert (events === exp_ev)
				else note_err("events pulse", {28'd0, exp_ev}, {28'd0, events});
		end
		ch_h3 = ch_h2;
		ch_h2 = ch_h1;
		ch_h1 = ch;
	end

	function automatic void expect_word(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		chk_cnt++;
		assert (act === exp) else note_err(name, exp, act);
	endfunction

	function automatic logic [APB_ADDR_W-1:0] timer_addr(input int t, input logic [4:0] offs);
		return {t[2:0], offs};
	endfunction

	function automatic logic [DATA_W-1:0] ch_word(input comp_op_t op, input int cmpv);
		return {14'd0, op, cmpv[15:0]};
	endfunction

	function automatic logic [DATA_W-1:0] range_word(input int lo, input int hi);
		return {hi[15:0], lo[15:0]};
	endfunction

	task automatic write_reg(input logic [APB_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		logic err;
		apb_write(addr, data, err);
		expect_word($sformatf("write %02h pslverr", addr), 32'd0, {31'd0, err});
	endtask

	task automatic read_reg(input logic [APB_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
		logic err;
		apb_read(addr, data, err);
		expect_word($sformatf("read %02h pslverr", addr), 32'd0, {31'd0, err});
	endtask

	task automatic send_cmd(input int t, input logic [DATA_W-1:0] cmd);
		write_reg(timer_addr(t, REG_CMD), cmd);
	endtask

	task automatic write_read_back(input logic [APB_ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] mask, input string name);
		logic [DATA_W-1:0] val;
		logic [DATA_W-1:0] rd;
		val = $urandom;
		write_reg(addr, val);
		read_reg(addr, rd);
		expect_word(name, val & mask, rd);
	endtask

	task automatic wait_level(input int idx, input logic level);
		while (ch[idx] !== level) begin
			@(negedge HCLK);
		end
	endtask

	task automatic hold_level(input int idx, input logic level, input int n);
		repeat (n) begin
			@(negedge HCLK);
			expect_word($sformatf("hold ch_o[%0d]", idx), {31'd0, level}, {31'd0, ch[idx]});
		end
	endtask

	// Measures one period from a rising edge of a channel to the next
	task automatic watch_edges(input int idx, output int hcnt, output int tcnt);
		logic prev;
		logic cur;
		prev = ch[idx];
		@(negedge HCLK);
		cur = ch[idx];
		while (!(cur && !prev)) begin
			prev = cur;
			@(negedge HCLK);
			cur = ch[idx];
		end
		hcnt = 1;
		tcnt = 1;
		prev = cur;
		@(negedge HCLK);
		cur = ch[idx];
		while (!(cur && !prev)) begin
			tcnt++;
			hcnt += int'(cur);
			prev = cur;
			@(negedge HCLK);
			cur = ch[idx];
		end
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////
	task automatic access_registers;
		logic [DATA_W-1:0] rd;
		logic              err;
		for (int t = 0; t < N_TIMERS; t++) begin
			write_read_back(timer_addr(t, REG_PRESC), 32'hFF, $sformatf("regs t%0d presc", t));
			write_read_back(timer_addr(t, REG_RANGE), 32'hFFFF_FFFF,
				$sformatf("regs t%0d range", t));
			write_read_back(timer_addr(t, REG_CH0), 32'h3FFFF, $sformatf("regs t%0d ch0", t));
			write_read_back(timer_addr(t, REG_CH1), 32'h3FFFF, $sformatf("regs t%0d ch1", t));
			read_reg(timer_addr(t, REG_CMD), rd);
			expect_word($sformatf("regs t%0d cmd", t), 32'd0, rd);
		end
		write_read_back(REG_EVENT, 32'hFFF, "regs event");
		apb_write(BAD_ADDR, $urandom, err);
		expect_word("unmapped write pslverr", 32'd1, {31'd0, err});
		apb_read(BAD_ADDR, rd, err);
		expect_word("unmapped read pslverr", 32'd1, {31'd0, err});
		expect_word("unmapped read data", 32'd0, rd);
	endtask

	task automatic control_counter;
		int                     lo;
		int                     hi;
		logic [DATA_W-1:0]      c1;
		logic [DATA_W-1:0]      c2;
		logic [N_TIMERS*N_CH-1:0] held;
		lo = $urandom % 100;
		hi = lo + 50 + $urandom % 100;
		write_reg(timer_addr(0, REG_PRESC), 32'd0);
		write_reg(timer_addr(0, REG_RANGE), range_word(lo, hi));
		write_reg(timer_addr(0, REG_CH0), ch_word(OP_TOGGLE, lo + 3));
		send_cmd(0, CMD_RST);
		send_cmd(0, CMD_START);
		repeat (40) @(negedge HCLK);
		send_cmd(0, CMD_STOP);
		read_reg(timer_addr(0, REG_COUNTER), c1);
		read_reg(timer_addr(0, REG_COUNTER), c2);
		expect_word("control frozen counter", c1, c2);
		chk_cnt++;
		assert (c1 >= lo && c1 <= hi) else begin
			err_cnt++;
			$display("ERR control counter range expected %0h..%0h actual %0h", lo, hi, c1);
		end
		// A compare on the frozen count would toggle ch_o[1] on any update without a tick
		write_reg(timer_addr(0, REG_CH1), ch_word(OP_TOGGLE, int'(c1)));
		held = ch;
		repeat (20) begin
			@(negedge HCLK);
			expect_word("control stopped ch_o", {28'd0, held}, {28'd0, ch});
		end
		send_cmd(0, CMD_RST);
		read_reg(timer_addr(0, REG_COUNTER), c1);
		expect_word("control reset counter", lo, c1);
		expect_word("control reset ch_o", 32'd0, {30'd0, ch[1:0]});
	endtask

	task automatic run_pwm(input int p);
		int lo;
		int span;
		int hi;
		int cmpv;
		int hcnt;
		int tcnt;
		lo = $urandom % 64;
		span = 20 + $urandom % 40;
		hi = lo + span;
		cmpv = lo + $urandom % span;
		send_cmd(0, CMD_STOP);
		write_reg(timer_addr(0, REG_PRESC), p);
		write_reg(timer_addr(0, REG_RANGE), range_word(lo, hi));
		write_reg(timer_addr(0, REG_CH0), ch_word(OP_PWM, cmpv));
		send_cmd(0, CMD_RST);
		send_cmd(0, CMD_START);
		repeat (2) begin
			watch_edges(0, hcnt, tcnt);
			expect_word($sformatf("pwm p%0d high", p), (hi - cmpv) * (p + 1), hcnt);
			expect_word($sformatf("pwm p%0d period", p), (span + 1) * (p + 1), tcnt);
		end
		send_cmd(0, CMD_STOP);
	endtask

	// Timer 1 runs a toggle on channel 0 and a set, later a reset, on channel 1
	task automatic run_match_ops;
		int lo;
		int span;
		int cmpv;
		int period;
		int hcnt;
		int tcnt;
		lo = $urandom % 64;
		span = 20 + $urandom % 40;
		cmpv = lo + $urandom % span;
		period = (span + 1) * 2;
		send_cmd(1, CMD_STOP);
		write_reg(timer_addr(1, REG_PRESC), 32'd1);
		write_reg(timer_addr(1, REG_RANGE), range_word(lo, lo + span));
		write_reg(timer_addr(1, REG_CH0), ch_word(OP_TOGGLE, cmpv));
		write_reg(timer_addr(1, REG_CH1), ch_word(OP_SET, cmpv));
		send_cmd(1, CMD_RST);
		send_cmd(1, CMD_START);
		watch_edges(2, hcnt, tcnt);
		expect_word("toggle rise interval", 2 * period, tcnt);
		wait_level(3, 1'b1);
		hold_level(3, 1'b1, period);
		write_reg(timer_addr(1, REG_CH1), ch_word(OP_RESET, cmpv));
		wait_level(3, 1'b0);
		hold_level(3, 1'b0, period);
		send_cmd(1, CMD_STOP);
	endtask

	task automatic run_events;
		int span0;
		int span1;
		send_cmd(0, CMD_STOP);
		send_cmd(1, CMD_STOP);
		span0 = 30 + $urandom % 20;
		span1 = 20 + $urandom % 20;
		write_reg(timer_addr(0, REG_PRESC), 32'd0);
		write_reg(timer_addr(0, REG_RANGE), range_word(0, span0));
		write_reg(timer_addr(0, REG_CH0), ch_word(OP_PWM, $urandom % span0));
		write_reg(timer_addr(0, REG_CH1), ch_word(OP_TOGGLE, $urandom % span0));
		write_reg(timer_addr(1, REG_PRESC), 32'd1);
		write_reg(timer_addr(1, REG_RANGE), range_word(5, 5 + span1));
		write_reg(timer_addr(1, REG_CH0), ch_word(OP_TOGGLE, 5 + $urandom % span1));
		write_reg(timer_addr(1, REG_CH1), ch_word(OP_SET, 5 + $urandom % span1));
		send_cmd(0, CMD_RST);
		send_cmd(1, CMD_RST);
		// Event 2 watches the set channel of timer 1 but stays disabled
		ev_sel_m = {2'd1, 2'd3, 2'd2, 2'd0};
		ev_en_m = 4'b1011;
		write_reg(REG_EVENT, {20'd0, ev_en_m, ev_sel_m});
		repeat (4) @(negedge HCLK);
		for (int k = 0; k < N_EVENTS; k++) begin
			rise_cnt[k] = 0;
			ev_cnt[k] = 0;
		end
		ev_chk = 1'b1;
		send_cmd(0, CMD_START);
		send_cmd(1, CMD_START);
		while (ev_cnt[0] < 3 || ev_cnt[1] < 2 || ev_cnt[3] < 2) begin
			@(negedge HCLK);
		end
		send_cmd(0, CMD_STOP);
		send_cmd(1, CMD_STOP);
		repeat (4) @(negedge HCLK);
		ev_chk = 1'b0;
		for (int k = 0; k < N_EVENTS; k++) begin
			expect_word($sformatf("events count %0d", k), ev_en_m[k] ? rise_cnt[k] : 0,
				ev_cnt[k]);
		end
	endtask

	initial begin
		void'($urandom(59191));
		HRESETn = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		pwrite  = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		repeat (16) @(negedge HCLK);
		HRESETn = 1'b1;
		access_registers();
		control_counter();
		run_pwm(0);
		run_pwm(3);
		run_match_ops();
		run_events();
		$display("Summary: %0d checks, %0d errors", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- adv_timer.f
+incdir+include
hdl/adv_timer_pkg.sv
hdl/adv_timer_regs.sv
hdl/timer_unit.sv
hdl/event_gen.sv
hdl/adv_timer_top.sv
tests/tb_adv_timer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the adv_timer testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_adv_timer \
	-f adv_timer.f -o tb_adv_timer_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_adv_timer_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Done: no errors" "$LOG"; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1
